//--- Makefile
TOP  := tb_ttc_lite
BIN  := obj_dir/V$(TOP)
SRCS := $(wildcard source/*.sv source/*.svh sim/*.sv)

.PHONY: all run clean

all: run

$(BIN): compile.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

//--- compile.f
+incdir+source
source/ttc_pkg.sv
source/ttc_reg_if.sv
source/ttc_apb_regs.sv
source/ttc_counter_lite.sv
source/ttc_interrupt_lite.sv
source/ttc_lite_top.sv
sim/tb_ttc_lite.sv

//--- sim/tb_ttc_lite.sv
`include "ttc_macros.svh"

module tb_ttc_lite;

  timeunit 1ns;
  timeprecision 100ps;

  // Word offsets within one timer window
  localparam int R_CTRL     = 0;
  localparam int R_INTERVAL = 1;
  localparam int R_MATCH1   = 2;
  localparam int R_MATCH2   = 3;
  localparam int R_MATCH3   = 4;
  localparam int R_COUNTER  = 5;
  localparam int R_STATUS   = 6;  // Clears on read
  localparam int R_EN       = 7;

  typedef enum int
  {
    OP_WRITE,
    OP_READ,    // Read and compare
    OP_RANGE,   // Read, value within bounds
    OP_WAIT,
    OP_LINES    // Compare interrupt lines
  } op_kind_e;

  typedef struct
  {
    op_kind_e                     kind;
    logic [`TTC_PADDR_WIDTH-1:0]  addr;
    logic [31:0]                  value;  // Data, expected, low bound or cycles
    logic [31:0]                  limit;  // High bound of a range read
    string                        name;
  } step_t;

  logic                          pclk9 = 1'b0;
  logic                          n_p_reset9;
  logic                          psel;
  logic                          penable;
  logic                          pwrite;
  logic [`TTC_PADDR_WIDTH-1:0]   paddr;
  logic [31:0]                   pwdata;
  logic [31:0]                   prdata;
  logic [`TTC_NUM_TIMERS-1:0]    interrupt;

  step_t steps[$];
  int    errors = 0;
  int    checks = 0;
  int    timeout_cycles = 0;   // Set once the table is built

  ttc_lite_top DUT (
    .pclk9      (pclk9),
    .n_p_reset9 (n_p_reset9),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .interrupt  (interrupt)
  );

  always #2 pclk9 = ~pclk9;   // 4 ns period

  // Timer in bits 6:5, word in bits 4:2
  function automatic void add_step(op_kind_e kind, int tmr, int off, logic [31:0] value,
                                   logic [31:0] limit, string name);
    step_t s;
    s.kind  = kind;
    s.addr  = `TTC_PADDR_WIDTH'((tmr << 5) | (off << 2));
    s.value = value;
    s.limit = limit;
    s.name  = name;
    steps.push_back(s);
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus table
  // --------------------------------------------------------------------------
  task automatic build_table();
    for (int t = 0; t < 4; t++)
      for (int r = 0; r < 8; r++)
        add_step(OP_READ, t, r, 0, 0, "reset value");   // Slot 3 included
    add_step(OP_LINES, 0, 0, 0, 0, "lines after reset");
    add_step(OP_WRITE, 0, R_INTERVAL, 'h5A, 0, "t0 interval");
    add_step(OP_READ,  0, R_INTERVAL, 'h5A, 0, "interval readback");
    add_step(OP_WRITE, 1, R_MATCH1, 'hA5, 0, "t1 match1");
    add_step(OP_READ,  1, R_MATCH1, 'hA5, 0, "match1 readback");
    add_step(OP_WRITE, 2, R_EN, 'h3F, 0, "t2 enable mask");
    add_step(OP_READ,  2, R_EN, 'h1F, 0, "enable reserved bit");  // Bit 5 stays 0
    add_step(OP_WRITE, 2, R_CTRL, 'h06, 0, "t2 ctrl");
    add_step(OP_READ,  2, R_CTRL, 'h02, 0, "ctrl restart reads 0");
    add_step(OP_WRITE, 2, R_CTRL, 0, 0, "t2 ctrl idle");
    add_step(OP_WRITE, 2, R_EN, 0, 0, "t2 mask off");
    // Timer 0 interval mode, interval and match1 unmasked
    add_step(OP_WRITE, 0, R_INTERVAL, 20, 0, "t0 interval");
    add_step(OP_WRITE, 0, R_MATCH1, 5, 0, "t0 match1");
    add_step(OP_WRITE, 0, R_EN, 'h03, 0, "t0 mask");
    add_step(OP_WRITE, 0, R_CTRL, 'h03, 0, "t0 start");
    add_step(OP_WAIT,  0, 0, 60, 0, "t0 run");
    add_step(OP_LINES, 0, 0, 'b001, 0, "t0 interrupt line");
    add_step(OP_WRITE, 0, R_CTRL, 0, 0, "t0 stop");
    add_step(OP_WAIT,  0, 0, 10, 0, "t0 settle");
    add_step(OP_READ,  0, R_STATUS, 'h03, 0, "t0 status");
    add_step(OP_WAIT,  0, 0, 4, 0, "t0 after read");
    add_step(OP_READ,  0, R_STATUS, 0, 0, "t0 status cleared");
    add_step(OP_LINES, 0, 0, 0, 0, "t0 line dropped");
    // Timer 1 masking, first all masked, then only match3
    add_step(OP_WRITE, 1, R_MATCH2, 10, 0, "t1 match2");
    add_step(OP_WRITE, 1, R_MATCH3, 30, 0, "t1 match3");
    add_step(OP_WRITE, 1, R_CTRL, 'h01, 0, "t1 start");
    add_step(OP_WAIT,  0, 0, 50, 0, "t1 masked run");
    add_step(OP_LINES, 0, 0, 0, 0, "masked events no line");
    add_step(OP_READ,  1, R_STATUS, 0, 0, "masked status empty");
    add_step(OP_WRITE, 1, R_EN, 'h08, 0, "t1 match3 mask");
    add_step(OP_WRITE, 1, R_CTRL, 'h05, 0, "t1 restart");
    add_step(OP_WAIT,  0, 0, 50, 0, "t1 run");
    add_step(OP_WRITE, 1, R_CTRL, 0, 0, "t1 stop");
    add_step(OP_WAIT,  0, 0, 8, 0, "t1 settle");
    add_step(OP_LINES, 0, 0, 'b010, 0, "t1 match3 line");
    add_step(OP_READ,  1, R_STATUS, 'h08, 0, "only match3 status");
    add_step(OP_LINES, 0, 0, 0, 0, "t1 line cleared");
    // Timer 2 free running through a wrap
    add_step(OP_WRITE, 2, R_EN, 'h10, 0, "t2 overflow mask");
    add_step(OP_WRITE, 2, R_CTRL, 'h01, 0, "t2 start");
    add_step(OP_WAIT,  0, 0, 300, 0, "t2 run");
    add_step(OP_LINES, 0, 0, 'b100, 0, "overflow line only");
    add_step(OP_WRITE, 2, R_CTRL, 0, 0, "t2 stop");
    add_step(OP_WAIT,  0, 0, 8, 0, "t2 settle");
    add_step(OP_READ,  2, R_STATUS, 'h10, 0, "overflow status");
    // Restart, then isolation between slots
    add_step(OP_WRITE, 2, R_CTRL, 'h01, 0, "t2 resume");
    add_step(OP_WAIT,  0, 0, 30, 0, "t2 count up");
    add_step(OP_WRITE, 2, R_CTRL, 'h05, 0, "t2 restart");
    add_step(OP_WAIT,  0, 0, 10, 0, "t2 short run");
    add_step(OP_WRITE, 2, R_CTRL, 0, 0, "t2 stop");
    add_step(OP_RANGE, 2, R_COUNTER, 10, 20, "count after restart");
    add_step(OP_READ,  2, R_CTRL, 0, 0, "t2 stopped");
    add_step(OP_WRITE, 0, R_MATCH3, 'h77, 0, "t0 match3");
    add_step(OP_READ,  0, R_MATCH3, 'h77, 0, "t0 match3 readback");
    add_step(OP_READ,  1, R_MATCH3, 30, 0, "t1 match3 kept");
    add_step(OP_READ,  2, R_MATCH3, 0, 0, "t2 match3 kept");
    add_step(OP_WRITE, 3, R_INTERVAL, 'hFF, 0, "slot3 write");
    add_step(OP_READ,  3, R_INTERVAL, 0, 0, "slot3 reads 0");
    add_step(OP_READ,  0, R_INTERVAL, 20, 0, "t0 interval kept");
    add_step(OP_READ,  1, R_INTERVAL, 0, 0, "t1 interval kept");
    add_step(OP_READ,  1, R_MATCH1, 'hA5, 0, "t1 match1 kept");
    add_step(OP_READ,  1, R_EN, 'h08, 0, "t1 mask kept");
    add_step(OP_LINES, 0, 0, 0, 0, "lines idle at end");
  endtask

  // --------------------------------------------------------------------------
  // APB transfers, driven 1 ns after the edge
  // --------------------------------------------------------------------------
  task automatic apb_write(input logic [`TTC_PADDR_WIDTH-1:0] addr, input logic [31:0] data);
    @(posedge pclk9);
    #1;
    psel    = 1'b1;   // Setup
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge pclk9);
    #1 penable = 1'b1;  // Access, write lands on next edge
    @(posedge pclk9);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [`TTC_PADDR_WIDTH-1:0] addr, output logic [31:0] data);
    @(posedge pclk9);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge pclk9);
    #1 penable = 1'b1;
    #1 data = prdata;   // Mid cycle, prdata settled
    @(posedge pclk9);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic run_step(input step_t s);
    logic [31:0] rdata;
    case (s.kind)
      OP_WRITE: apb_write(s.addr, s.value);
      OP_READ:
      begin
        apb_read(s.addr, rdata);
        checks++;
        if (rdata !== s.value)
        begin
          errors++;
          $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", s.name, s.value, rdata);
        end
      end
      OP_RANGE:
      begin
        apb_read(s.addr, rdata);
        checks++;
        if (rdata < s.value || rdata > s.limit)
        begin
          errors++;
          $display("CHECK FAILED %s: expected 0x%0h to 0x%0h, actual 0x%0h",
                   s.name, s.value, s.limit, rdata);
        end
      end
      OP_WAIT:
      begin
        repeat (s.value) @(posedge pclk9);
        #1;
      end
      OP_LINES:
      begin
        @(posedge pclk9);
        #1;
        checks++;
        if (interrupt !== s.value[`TTC_NUM_TIMERS-1:0])
        begin
          errors++;
          $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", s.name,
                   s.value[`TTC_NUM_TIMERS-1:0], interrupt);
        end
      end
      default: ;
    endcase
  endtask

  // --------------------------------------------------------------------------
  // Sequence and watchdog
  // --------------------------------------------------------------------------
  initial
  begin
    int budget;
    n_p_reset9 = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    build_table();
    budget = 8 + 200;   // Reset plus margin
    foreach (steps[i])
      budget += (steps[i].kind == OP_WAIT) ? int'(steps[i].value) : 4;
    timeout_cycles = budget;
    repeat (8) @(posedge pclk9);
    #1 n_p_reset9 = 1'b1;
    foreach (steps[i])
      run_step(steps[i]);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial
  begin
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge pclk9);
    $display("Timeout: the test sequence ran past %0d cycles", timeout_cycles);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- source/ttc_apb_regs.sv
`include "ttc_macros.svh"

module ttc_apb_regs (
  input  logic                          pclk9,
  input  logic                          n_p_reset9,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [`TTC_PADDR_WIDTH-1:0]   paddr,
  input  logic [`TTC_PDATA_WIDTH-1:0]   pwdata,
  output logic [`TTC_PDATA_WIDTH-1:0]   prdata,
  ttc_reg_if.decoder                    regs [`TTC_NUM_TIMERS]
);

  localparam int TMR_BITS = `TTC_TMR_MSB - `TTC_TMR_LSB + 1;

  // --------------------------------------------------------------------------
  // Address split and access phase qualifiers
  // --------------------------------------------------------------------------
  logic [TMR_BITS-1:0]  tmr_idx;        // Addressed timer slot
  ttc_pkg::ttc_reg_e    reg_off;        // Addressed word in that slot
  logic                 wr_acc;         // Write in access phase
  logic                 rd_acc;         // Read in access phase
  logic [`TTC_NUM_TIMERS-1:0][`TTC_PDATA_WIDTH-1:0] rd_all;  // Per-timer read words

  assign tmr_idx = paddr[`TTC_TMR_MSB:`TTC_TMR_LSB];
  assign reg_off = ttc_pkg::ttc_reg_e'(paddr[`TTC_REG_MSB:`TTC_REG_LSB]);
  assign wr_acc  = psel & penable & pwrite;
  assign rd_acc  = psel & penable & ~pwrite;

  // --------------------------------------------------------------------------
  // Per-timer strobes and read words
  // --------------------------------------------------------------------------
  for (genvar t = 0; t < `TTC_NUM_TIMERS; t++)
  begin : g_tmr
    logic                         hit;      // This slot addressed
    logic [`TTC_PDATA_WIDTH-1:0]  rd_word;

    assign hit = (tmr_idx == TMR_BITS'(t));

    assign regs[t].wdata        = pwdata[`TTC_CNT_WIDTH-1:0];
    assign regs[t].ctrl_sel     = wr_acc & hit & (reg_off == ttc_pkg::CNTR_CTRL);
    assign regs[t].interval_sel = wr_acc & hit & (reg_off == ttc_pkg::INTERVAL);
    assign regs[t].match_sel[1] = wr_acc & hit & (reg_off == ttc_pkg::MATCH1);
    assign regs[t].match_sel[2] = wr_acc & hit & (reg_off == ttc_pkg::MATCH2);
    assign regs[t].match_sel[3] = wr_acc & hit & (reg_off == ttc_pkg::MATCH3);
    assign regs[t].intr_en_sel  = wr_acc & hit & (reg_off == ttc_pkg::INTR_EN);
    // Status clears on its read, not on a write
    assign regs[t].clear_interrupt = rd_acc & hit & (reg_off == ttc_pkg::INTR_STATUS);

    // Zero-extended read-back, restart bit reads 0
    always_comb
    begin
      rd_word = '0;
      case (reg_off)
        ttc_pkg::CNTR_CTRL:   rd_word[1:0] = regs[t].cnt_ctrl;
        ttc_pkg::INTERVAL:    rd_word[`TTC_CNT_WIDTH-1:0] = regs[t].interval_value;
        ttc_pkg::MATCH1:      rd_word[`TTC_CNT_WIDTH-1:0] = regs[t].match_value[1];
        ttc_pkg::MATCH2:      rd_word[`TTC_CNT_WIDTH-1:0] = regs[t].match_value[2];
        ttc_pkg::MATCH3:      rd_word[`TTC_CNT_WIDTH-1:0] = regs[t].match_value[3];
        ttc_pkg::COUNTER:     rd_word[`TTC_CNT_WIDTH-1:0] = regs[t].counter_value;
        ttc_pkg::INTR_STATUS: rd_word[`TTC_INTR_WIDTH-1:0] = regs[t].interrupt_reg;
        ttc_pkg::INTR_EN:     rd_word[`TTC_INTR_WIDTH-1:0] = regs[t].interrupt_en;
        default:              rd_word = '0;
      endcase
    end

    assign rd_all[t] = rd_word;
  end

  // --------------------------------------------------------------------------
  // Read mux, empty slot reads zero
  // --------------------------------------------------------------------------
  always_comb
  begin
    prdata = '0;
    for (int t = 0; t < `TTC_NUM_TIMERS; t++)
    begin
      if (tmr_idx == TMR_BITS'(t))
        prdata = rd_all[t];
    end
  end

  // Access phase only follows a setup phase of the same transfer
  a_apb_setup_before_access: assert property (
    @(posedge pclk9) disable iff (!n_p_reset9)
    $rose(penable) |-> (psel && $past(psel))
  );

endmodule

//--- source/ttc_counter_lite.sv
`include "ttc_macros.svh"

module ttc_counter_lite (
  input  logic       pclk9,
  input  logic       n_p_reset9,
  ttc_reg_if.timer   bus,
  output logic       interval_intr,   // Interval reached, one cycle
  output logic [3:1] match_intr,      // Match comparators, one cycle each
  output logic       overflow_intr    // Free-running wrap, one cycle
);

  // --------------------------------------------------------------------------
  // Registers
  // --------------------------------------------------------------------------
  ttc_pkg::ttc_cnt_ctrl_t          cnt_ctrl;
  logic [`TTC_CNT_WIDTH-1:0]       interval_reg;
  logic [3:1][`TTC_CNT_WIDTH-1:0]  match_reg;
  logic [`TTC_CNT_WIDTH-1:0]       count;

  logic restart;      // Write-only bit 2 of control
  logic at_interval;  // Counter at or past interval
  logic at_wrap;      // Free-running counter about to wrap

  assign restart     = bus.ctrl_sel & bus.wdata[2];
  assign at_interval = cnt_ctrl.interval_mode & (count >= interval_reg);
  assign at_wrap     = ~cnt_ctrl.interval_mode & (count == '1);

  // Control, interval and match registers
  always_ff @(posedge pclk9 or negedge n_p_reset9)
  begin
    if (!n_p_reset9)
    begin
      cnt_ctrl     <= '0;
      interval_reg <= '0;
      match_reg    <= '0;
    end
    else
    begin
      if (bus.ctrl_sel)
        cnt_ctrl <= ttc_pkg::ttc_cnt_ctrl_t'(bus.wdata[1:0]);  // Bits 1:0 stored
      if (bus.interval_sel)
        interval_reg <= bus.wdata;
      for (int i = 1; i <= 3; i++)
      begin
        if (bus.match_sel[i])
          match_reg[i] <= bus.wdata;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Counter
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk9 or negedge n_p_reset9)
  begin
    if (!n_p_reset9)
      count <= '0;
    else if (restart)
      count <= '0;                        // Restart wins over counting
    else if (cnt_ctrl.enable)
    begin
      if (at_interval)
        count <= '0;
      else
        count <= count + 1'b1;            // Wraps naturally in free mode
    end
  end

  // Registered event pulses
  always_ff @(posedge pclk9 or negedge n_p_reset9)
  begin
    if (!n_p_reset9)
    begin
      interval_intr <= 1'b0;
      overflow_intr <= 1'b0;
      match_intr    <= '0;
    end
    else
    begin
      interval_intr <= cnt_ctrl.enable & ~restart & at_interval;
      overflow_intr <= cnt_ctrl.enable & ~restart & at_wrap;
      for (int i = 1; i <= 3; i++)
        match_intr[i] <= cnt_ctrl.enable & (count == match_reg[i]);  // Moving counter only
    end
  end

  // Read-back
  assign bus.cnt_ctrl       = cnt_ctrl;
  assign bus.interval_value = interval_reg;
  assign bus.match_value    = match_reg;
  assign bus.counter_value  = count;

  // Once settled in interval mode, the counter stays within the interval
  a_interval_bound: assert property (
    @(posedge pclk9) disable iff (!n_p_reset9)
    ($past(cnt_ctrl.enable && cnt_ctrl.interval_mode) && cnt_ctrl.interval_mode &&
     $stable(interval_reg)) |-> (count <= interval_reg)
  );

endmodule

//--- source/ttc_interrupt_lite.sv
`include "ttc_macros.svh"

module ttc_interrupt_lite (
  input  logic       pclk9,
  input  logic       n_p_reset9,
  ttc_reg_if.timer   bus,             // Interrupt fields only
  input  logic       interval_intr,
  input  logic [3:1] match_intr,
  input  logic       overflow_intr,
  output logic       interrupt
);

  logic [`TTC_INTR_WIDTH-1:0] intr_detect;       // Raw events, bit 5 reserved
  logic [`TTC_INTR_WIDTH-1:0] int_sync_reg;      // Previous events for edge detect
  logic [`TTC_INTR_WIDTH-1:0] int_cycle_reg;     // Rising edges, one cycle
  logic [`TTC_INTR_WIDTH-1:0] interrupt_reg;     // Sticky masked status
  logic [`TTC_INTR_WIDTH-1:0] interrupt_en_reg;
  logic                       interrupt_set;     // Capture last cycle, blocks clear

  assign intr_detect = {1'b0, overflow_intr, match_intr[3], match_intr[2],
                        match_intr[1], interval_intr};

  // --------------------------------------------------------------------------
  // Edge capture and sticky status
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk9 or negedge n_p_reset9)
  begin
    if (!n_p_reset9)
    begin
      int_sync_reg  <= '0;
      int_cycle_reg <= '0;
      interrupt_reg <= '0;
      interrupt_set <= 1'b0;
    end
    else
    begin
      int_sync_reg  <= intr_detect;
      int_cycle_reg <= intr_detect & ~int_sync_reg;   // Rising edges
      interrupt_set <= |int_cycle_reg;
      // Fresh captures survive a clear in the same cycle
      if (bus.clear_interrupt && !interrupt_set)
        interrupt_reg <= int_cycle_reg & interrupt_en_reg;
      else
        interrupt_reg <= interrupt_reg | (int_cycle_reg & interrupt_en_reg);
    end
  end

  // Enable register, reserved bit held at 0
  always_ff @(posedge pclk9 or negedge n_p_reset9)
  begin
    if (!n_p_reset9)
      interrupt_en_reg <= '0;
    else if (bus.intr_en_sel)
      interrupt_en_reg <= {1'b0, bus.wdata[`TTC_INTR_WIDTH-2:0]};
  end

  assign interrupt         = |interrupt_reg;
  assign bus.interrupt_reg = interrupt_reg;
  assign bus.interrupt_en  = interrupt_en_reg;

  // Enabled rising edge lands in status two edges later even across a clear
  for (genvar i = 0; i < `TTC_INTR_WIDTH-1; i++)
  begin : g_capture_chk
    a_edge_sets_status: assert property (
      @(posedge pclk9) disable iff (!n_p_reset9)
      ($past(intr_detect[i], 2) && !$past(intr_detect[i], 3) &&
       $past(interrupt_en_reg[i])) |-> interrupt_reg[i]
    );
  end

endmodule

//--- source/ttc_lite_top.sv
`include "ttc_macros.svh"

module ttc_lite_top (
  input  logic                          pclk9,
  input  logic                          n_p_reset9,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [`TTC_PADDR_WIDTH-1:0]   paddr,
  input  logic [`TTC_PDATA_WIDTH-1:0]   pwdata,
  output logic [`TTC_PDATA_WIDTH-1:0]   prdata,
  output logic [`TTC_NUM_TIMERS-1:0]    interrupt   // One line per timer
);

  // Register bus, one per timer
  ttc_reg_if regs [`TTC_NUM_TIMERS] ();

  ttc_apb_regs u_apb_regs (
    .pclk9      (pclk9),
    .n_p_reset9 (n_p_reset9),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .regs       (regs)
  );

  // --------------------------------------------------------------------------
  // Timers and their interrupt blocks
  // --------------------------------------------------------------------------
  for (genvar t = 0; t < `TTC_NUM_TIMERS; t++)
  begin : g_timer
    logic       interval_intr;
    logic [3:1] match_intr;
    logic       overflow_intr;

    ttc_counter_lite u_counter (
      .pclk9         (pclk9),
      .n_p_reset9    (n_p_reset9),
      .bus           (regs[t]),
      .interval_intr (interval_intr),
      .match_intr    (match_intr),
      .overflow_intr (overflow_intr)
    );

    ttc_interrupt_lite u_interrupt (
      .pclk9         (pclk9),
      .n_p_reset9    (n_p_reset9),
      .bus           (regs[t]),
      .interval_intr (interval_intr),
      .match_intr    (match_intr),
      .overflow_intr (overflow_intr),
      .interrupt     (interrupt[t])
    );
  end

endmodule

//--- source/ttc_macros.svh
`ifndef TTC_MACROS_SVH
`define TTC_MACROS_SVH

// ------------------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------------------
`define TTC_CNT_WIDTH    8   // Counter, interval and match width
`define TTC_NUM_TIMERS   3   // Timers in the block
`define TTC_INTR_WIDTH   6   // Interrupt status and enable width
`define TTC_PDATA_WIDTH  32  // APB data bus

// ------------------------------------------------------------------------
// APB address layout
// ------------------------------------------------------------------------
`define TTC_PADDR_WIDTH  8
`define TTC_REG_LSB      2   // Word offset within a timer
`define TTC_REG_MSB      4
`define TTC_TMR_LSB      5   // Timer slot
`define TTC_TMR_MSB      6

`endif

//--- source/ttc_pkg.sv
`include "ttc_macros.svh"

package ttc_pkg;

  // Word offsets inside one timer's register window
  typedef enum logic [2:0]
  {
    CNTR_CTRL   = 3'd0,
    INTERVAL    = 3'd1,
    MATCH1      = 3'd2,
    MATCH2      = 3'd3,
    MATCH3      = 3'd4,
    COUNTER     = 3'd5,
    INTR_STATUS = 3'd6,  // Clear on read
    INTR_EN     = 3'd7
  } ttc_reg_e;

  // Counter-sized value
  typedef logic [`TTC_CNT_WIDTH-1:0] ttc_cnt_t;

  // Stored part of the control register, restart is not kept
  typedef struct packed
  {
    logic interval_mode;  // Bit 1
    logic enable;         // Bit 0
  } ttc_cnt_ctrl_t;

endpackage

//--- source/ttc_reg_if.sv
`include "ttc_macros.svh"

interface ttc_reg_if;

  // Decoder to timer
  ttc_pkg::ttc_cnt_t wdata;               // Write data, low byte of pwdata
  logic              ctrl_sel;            // Control write strobe
  logic              interval_sel;        // Interval write strobe
  logic [3:1]        match_sel;           // One-hot match write strobes
  logic              intr_en_sel;         // Interrupt enable write strobe
  logic              clear_interrupt;     // Status read, clears sticky bits

  // Timer to decoder, read-back values
  ttc_pkg::ttc_cnt_ctrl_t           cnt_ctrl;
  ttc_pkg::ttc_cnt_t                interval_value;
  logic [3:1][`TTC_CNT_WIDTH-1:0]   match_value;
  ttc_pkg::ttc_cnt_t                counter_value;
  logic [`TTC_INTR_WIDTH-1:0]       interrupt_reg;  // Sticky status
  logic [`TTC_INTR_WIDTH-1:0]       interrupt_en;

  modport decoder (
    output wdata, ctrl_sel, interval_sel, match_sel, intr_en_sel, clear_interrupt,
    input  cnt_ctrl, interval_value, match_value, counter_value,
    input  interrupt_reg, interrupt_en
  );

  modport timer (
    input  wdata, ctrl_sel, interval_sel, match_sel, intr_en_sel, clear_interrupt,
    output cnt_ctrl, interval_value, match_value, counter_value,
    output interrupt_reg, interrupt_en
  );

endinterface
